// File: design/mips_defines.svh
// opcode and funct codes, boot vector and word width for the mips core
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

`define MIPS_WORD 32
`define MIPS_RESET_VECTOR 32'hBFC0_0000 // boot rom entry point

// primary opcodes, instr[31:26]
`define OP_RTYPE 6'h00
`define OP_J     6'h02
`define OP_BEQ   6'h04
`define OP_BNE   6'h05
`define OP_ADDIU 6'h09
`define OP_ANDI  6'h0C
`define OP_ORI   6'h0D
`define OP_LUI   6'h0F

// funct codes for r-type, instr[5:0]
`define FN_ADDU 6'h21
`define FN_SUBU 6'h23
`define FN_AND  6'h24
`define FN_OR   6'h25
`define FN_SLT  6'h2A

`endif

// File: design/mips_pkg.sv
// instruction word field views, instruction union and alu operation enum
`default_nettype none

package mips_pkg;

  // register-register format
  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } r_fields_t;

  // immediate format, also used by branches
  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } i_fields_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] target; // word index within the current 256MB region
  } j_fields_t;

  // one fetched word, read through whichever format the opcode calls for
  typedef union packed {
    r_fields_t r;
    i_fields_t i;
    j_fields_t j;
  } instr_t;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_SLT = 3'd4,
    ALU_LUI = 3'd5
  } alu_op_t;

endpackage

`default_nettype wire

// File: design/reg_file.sv
// 32 entry register file, two async read ports, one sync write port, $v0 tap
`default_nettype none

`include "mips_defines.svh"

module reg_file (
  input  logic        clk,
  input  logic        reset,
  input  logic        write_en,
  input  logic [4:0]  read_addr1,
  input  logic [4:0]  read_addr2,
  input  logic [4:0]  write_addr,
  input  logic [31:0] write_data,
  output logic [31:0] read_data1,
  output logic [31:0] read_data2,
  output logic [31:0] reg_v0
);

  logic [`MIPS_WORD-1:0] regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en && (write_addr != 5'd0)) begin
      regs[write_addr] <= write_data; // $zero never takes a write
    end
  end

  // register zero is hardwired, so mask the read as well
  assign read_data1 = (read_addr1 != 5'd0) ? regs[read_addr1] : '0;
  assign read_data2 = (read_addr2 != 5'd0) ? regs[read_addr2] : '0;

  assign reg_v0 = regs[2]; // $v0 for observation

endmodule

`default_nettype wire

// File: design/program_counter.sv
// program counter with boot vector, enable and sequential/branch/jump next address
`default_nettype none

`include "mips_defines.svh"

module program_counter (
  input  logic        clk,
  input  logic        reset,
  input  logic        enable,
  input  logic        branch_eq,
  input  logic        branch_ne,
  input  logic        jump,
  input  logic        alu_zero,
  input  logic [15:0] imm,
  input  logic [25:0] target,
  output logic [31:0] pc
);

  logic [`MIPS_WORD-1:0] pc_plus4;
  logic [`MIPS_WORD-1:0] branch_offset;
  logic [`MIPS_WORD-1:0] branch_target;
  logic [`MIPS_WORD-1:0] jump_target;
  logic [`MIPS_WORD-1:0] next_pc;
  logic                  take_branch;

  assign pc_plus4 = pc + 32'd4;

  // sign extended word offset, relative to the following instruction
  assign branch_offset = {{14{imm[15]}}, imm, 2'b00};
  assign branch_target = pc_plus4 + branch_offset;

  assign jump_target = {pc_plus4[31:28], target, 2'b00}; // stays in the current region

  // the alu subtracts rs - rt for both branch kinds
  assign take_branch = (branch_eq & alu_zero) | (branch_ne & ~alu_zero);

  always_comb begin
    if (jump) begin
      next_pc = jump_target;
    end else if (take_branch) begin
      next_pc = branch_target;
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= `MIPS_RESET_VECTOR;
    end else if (enable) begin
      pc <= next_pc; // no delay slot
    end
  end

endmodule

`default_nettype wire

// File: design/alu.sv
// 32-bit alu: add, subtract, and, or, signed set-less-than, upper immediate
`default_nettype none

`include "mips_defines.svh"

module alu (
  input  mips_pkg::alu_op_t op,
  input  logic [31:0]       a,
  input  logic [31:0]       b,
  output logic [31:0]       result,
  output logic              zero
);

  import mips_pkg::*;

  logic less_than;

  assign less_than = $signed(a) < $signed(b);

  always_comb begin
    case (op)
      ALU_ADD: result = a + b;
      ALU_SUB: result = a - b;
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_SLT: result = {{(`MIPS_WORD-1){1'b0}}, less_than};
      ALU_LUI: result = {b[15:0], 16'h0000}; // immediate to the top half
      default: result = '0;
    endcase
  end

  // beq/bne look at this after a subtract
  assign zero = (result == '0);

endmodule

`default_nettype wire

// File: design/control_decoder.sv
// main decoder, opcode and funct to register, immediate, alu and branch controls
`default_nettype none

`include "mips_defines.svh"

module control_decoder (
  input  logic [5:0]        opcode,
  input  logic [5:0]        funct,
  output logic              reg_write,
  output logic              reg_dst_rd,
  output logic              alu_src_imm,
  output logic              zero_ext_imm,
  output logic              branch_eq,
  output logic              branch_ne,
  output logic              jump,
  output mips_pkg::alu_op_t alu_op
);

  import mips_pkg::*;

  always_comb begin
    // anything not listed below falls through as a no-op
    reg_write    = 1'b0;
    reg_dst_rd   = 1'b0;
    alu_src_imm  = 1'b0;
    zero_ext_imm = 1'b0;
    branch_eq    = 1'b0;
    branch_ne    = 1'b0;
    jump         = 1'b0;
    alu_op       = ALU_ADD;

    case (opcode)
      `OP_RTYPE: begin
        reg_dst_rd = 1'b1;
        reg_write  = 1'b1;
        case (funct)
          `FN_ADDU: alu_op = ALU_ADD;
          `FN_SUBU: alu_op = ALU_SUB;
          `FN_AND:  alu_op = ALU_AND;
          `FN_OR:   alu_op = ALU_OR;
          `FN_SLT:  alu_op = ALU_SLT;
          default:  reg_write = 1'b0; // unsupported funct
        endcase
      end
      `OP_ADDIU: begin
        reg_write   = 1'b1;
        alu_src_imm = 1'b1; // sign extended
      end
      `OP_ANDI: begin
        reg_write    = 1'b1;
        alu_src_imm  = 1'b1;
        zero_ext_imm = 1'b1;
        alu_op       = ALU_AND;
      end
      `OP_ORI: begin
        reg_write    = 1'b1;
        alu_src_imm  = 1'b1;
        zero_ext_imm = 1'b1;
        alu_op       = ALU_OR;
      end
      `OP_LUI: begin
        reg_write    = 1'b1;
        alu_src_imm  = 1'b1;
        zero_ext_imm = 1'b1; // only the low half reaches the alu anyway
        alu_op       = ALU_LUI;
      end
      `OP_BEQ: begin
        branch_eq = 1'b1;
        alu_op    = ALU_SUB; // compare rs with rt
      end
      `OP_BNE: begin
        branch_ne = 1'b1;
        alu_op    = ALU_SUB;
      end
      `OP_J:   jump = 1'b1;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: design/mips_core.sv
// single-cycle mips core top: decode, register file, alu, pc and operand muxing
`default_nettype none

`include "mips_defines.svh"

module mips_core (
  input  logic        clk,
  input  logic        reset,
  input  logic        clk_enable,
  input  logic [31:0] instr_data,
  output logic [31:0] instr_address,
  output logic [31:0] register_v0
);

  import mips_pkg::*;

  instr_t                instr;
  logic                  reg_write;
  logic                  reg_dst_rd;
  logic                  alu_src_imm;
  logic                  zero_ext_imm;
  logic                  branch_eq;
  logic                  branch_ne;
  logic                  jump;
  alu_op_t               alu_op;
  logic [4:0]            write_addr;
  logic [`MIPS_WORD-1:0] rd1;
  logic [`MIPS_WORD-1:0] rd2;
  logic [`MIPS_WORD-1:0] imm_ext;
  logic [`MIPS_WORD-1:0] alu_b;
  logic [`MIPS_WORD-1:0] alu_result;
  logic                  alu_zero;

  assign instr = instr_t'(instr_data);

  control_decoder u_control_decoder (
    .opcode       (instr.r.opcode),
    .funct        (instr.r.funct),
    .reg_write    (reg_write),
    .reg_dst_rd   (reg_dst_rd),
    .alu_src_imm  (alu_src_imm),
    .zero_ext_imm (zero_ext_imm),
    .branch_eq    (branch_eq),
    .branch_ne    (branch_ne),
    .jump         (jump),
    .alu_op       (alu_op)
  );

  assign write_addr = reg_dst_rd ? instr.r.rd : instr.i.rt; // r-type writes rd

  reg_file u_reg_file (
    .clk        (clk),
    .reset      (reset),
    .write_en   (reg_write & clk_enable), // a frozen core must not commit
    .read_addr1 (instr.r.rs),
    .read_addr2 (instr.i.rt),
    .write_addr (write_addr),
    .write_data (alu_result),
    .read_data1 (rd1),
    .read_data2 (rd2),
    .reg_v0     (register_v0)
  );

  // logical immediates are zero extended, arithmetic ones sign extended
  assign imm_ext = zero_ext_imm ? {16'h0000, instr.i.imm}
                                : {{16{instr.i.imm[15]}}, instr.i.imm};
  assign alu_b = alu_src_imm ? imm_ext : rd2;

  alu u_alu (
    .op     (alu_op),
    .a      (rd1),
    .b      (alu_b),
    .result (alu_result),
    .zero   (alu_zero)
  );

  program_counter u_program_counter (
    .clk       (clk),
    .reset     (reset),
    .enable    (clk_enable),
    .branch_eq (branch_eq),
    .branch_ne (branch_ne),
    .jump      (jump),
    .alu_zero  (alu_zero),
    .imm       (instr.i.imm),
    .target    (instr.j.target),
    .pc        (instr_address)
  );

endmodule

`default_nettype wire

// File: test/mips_core_tb.sv
// testbench for mips_core: program memory model, lfsr, value checks and directed tests
`default_nettype none

`include "mips_defines.svh"

module mips_core_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] vec = `MIPS_RESET_VECTOR;
  localparam logic [4:0] r_zero = 5'd0;
  localparam logic [4:0] r_v0 = 5'd2;
  localparam logic [4:0] r_t0 = 5'd8;
  localparam logic [4:0] r_t1 = 5'd9;

  logic        clk;
  logic        reset;
  logic        clk_enable;
  logic [31:0] instr_data;
  logic [31:0] instr_address;
  logic [31:0] register_v0;
  logic [31:0] prog [64]; // word 0 sits at the reset vector
  logic [31:0] offset;
  logic [31:0] lfsr;
  int          checks;
  int          errors;
  int          timeouts;

  mips_core u_mips_core (
    .clk           (clk),
    .reset         (reset),
    .clk_enable    (clk_enable),
    .instr_data    (instr_data),
    .instr_address (instr_address),
    .register_v0   (register_v0)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // combinational fetch, anything outside the array reads as a nop
  always_comb begin
    offset = instr_address - vec;
    if (offset < 32'd256) begin
      instr_data = prog[offset[7:2]];
    end else begin
      instr_data = 32'h0;
    end
  end

  function automatic logic [31:0] rtype_word(input logic [4:0] rs, input logic [4:0] rt,
                                             input logic [4:0] rd, input logic [5:0] fn);
    return {`OP_RTYPE, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] jump_word(input logic [31:0] dest);
    return {`OP_J, dest[27:2]};
  endfunction

  // x^32 + x^22 + x^2 + x + 1, right shifting form
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic random_word(output logic [31:0] w);
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr = lfsr_step(lfsr);
      w = {w[30:0], lfsr[0]}; // one step per bit
    end
  endtask

  function automatic logic [31:0] branch_dest(input logic [31:0] pc, input logic [15:0] off);
    logic [31:0] ext;
    ext = {{16{off[15]}}, off};
    return pc + 32'd4 + (ext << 2);
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic clear_program;
    for (int i = 0; i < 64; i++) begin
      prog[i] = 32'h0;
    end
  endtask

  task automatic apply_reset;
    @(posedge clk);
    reset <= 1'b1;
    clk_enable <= 1'b1;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk); // outputs settle here
  endtask

  task automatic run_cycles(input int n);
    repeat (n) @(posedge clk);
    @(negedge clk);
  endtask

  task automatic wait_for_pc(input string name, input logic [31:0] addr, input int limit);
    int cycles;
    cycles = 0;
    while (instr_address !== addr && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (instr_address !== addr) begin
      timeouts++;
      $display("%s: timed out after %0d cycles waiting for instr_address %h", name, limit, addr);
    end
  endtask

  task automatic reset_and_idle;
    clear_program();
    prog[0] = itype_word(`OP_ORI, r_zero, r_v0, 16'hA5A5);
    apply_reset();
    run_cycles(1);
    check_value("pre_reset_v0", 32'h0000_A5A5, register_v0); // something for reset to clear
    clear_program();
    apply_reset();
    check_value("reset_pc", vec, instr_address);
    check_value("reset_v0", 32'h0, register_v0);
    run_cycles(5);
    check_value("idle_pc", vec + 32'd20, instr_address);
  endtask

  task automatic immediate_ops;
    logic [31:0] exp;
    clear_program();
    prog[0] = itype_word(`OP_LUI, r_zero, r_v0, 16'h8001);
    prog[1] = itype_word(`OP_ORI, r_v0, r_v0, 16'hF00F);
    prog[2] = itype_word(`OP_ADDIU, r_v0, r_v0, 16'hFFF0);
    prog[3] = itype_word(`OP_ANDI, r_v0, r_v0, 16'hF0F0);
    prog[4] = jump_word(vec + 32'd16);
    apply_reset();
    exp = {16'h8001, 16'h0}; // lui moves the immediate up
    run_cycles(1);
    check_value("lui", exp, register_v0);
    exp = exp | {16'h0, 16'hF00F};
    run_cycles(1);
    check_value("ori", exp, register_v0);
    exp = exp + {{16{1'b1}}, 16'hFFF0}; // sign extended, so minus 16
    run_cycles(1);
    check_value("addiu", exp, register_v0);
    exp = exp & {16'h0, 16'hF0F0};
    run_cycles(1);
    check_value("andi", exp, register_v0);
    wait_for_pc("immediate_ops", vec + 32'd16, 4);
  endtask

  task automatic rtype_ops;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] exp;
    logic [5:0]  fn [5];
    fn = '{`FN_ADDU, `FN_SUBU, `FN_AND, `FN_OR, `FN_SLT};
    for (int pass = 0; pass < 3; pass++) begin
      random_word(a);
      random_word(b);
      if (pass == 0) begin
        a[31] = 1'b1; // opposite signs, so slt must compare signed
        b[31] = 1'b0;
      end
      clear_program();
      prog[0] = itype_word(`OP_LUI, r_zero, r_t0, a[31:16]);
      prog[1] = itype_word(`OP_ORI, r_t0, r_t0, a[15:0]);
      prog[2] = itype_word(`OP_LUI, r_zero, r_t1, b[31:16]);
      prog[3] = itype_word(`OP_ORI, r_t1, r_t1, b[15:0]);
      for (int k = 0; k < 5; k++) begin
        prog[4 + k] = rtype_word(r_t0, r_t1, r_v0, fn[k]);
      end
      prog[9] = jump_word(vec + 32'd36);
      apply_reset();
      run_cycles(4); // operands now in $t0 and $t1
      for (int k = 0; k < 5; k++) begin
        case (k)
          0: exp = a + b;
          1: exp = a - b;
          2: exp = a & b;
          3: exp = a | b;
          default: exp = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
        run_cycles(1);
        check_value($sformatf("rtype_%0d_funct_%h", pass, fn[k]), exp, register_v0);
      end
      wait_for_pc("rtype_ops", vec + 32'd36, 4);
    end
  endtask

  task automatic zero_register;
    clear_program();
    prog[0] = itype_word(`OP_LUI, r_zero, r_v0, 16'h5555);
    prog[1] = itype_word(`OP_ADDIU, r_zero, r_zero, 16'h1234);
    prog[2] = itype_word(`OP_ORI, r_zero, r_zero, 16'hFFFF);
    prog[3] = rtype_word(r_zero, r_zero, r_v0, `FN_ADDU);
    prog[4] = jump_word(vec + 32'd16);
    apply_reset();
    run_cycles(1);
    check_value("zero_setup", 32'h5555_0000, register_v0);
    run_cycles(3);
    check_value("zero_reads_zero", 32'h0, register_v0);
    wait_for_pc("zero_register", vec + 32'd16, 4);
  endtask

  task automatic control_flow;
    logic [31:0] pc;
    clear_program();
    prog[0]  = itype_word(`OP_ORI, r_zero, r_t0, 16'd5);
    prog[1]  = itype_word(`OP_ORI, r_zero, r_t1, 16'd5);
    prog[2]  = itype_word(`OP_BEQ, r_t0, r_t1, 16'd2);   // taken
    prog[3]  = itype_word(`OP_ORI, r_zero, r_v0, 16'h0BAD);
    prog[4]  = itype_word(`OP_ORI, r_zero, r_v0, 16'h0BAD);
    prog[5]  = itype_word(`OP_BNE, r_t0, r_t1, 16'd3);   // not taken
    prog[6]  = itype_word(`OP_ORI, r_zero, r_v0, 16'h0011);
    prog[7]  = itype_word(`OP_BNE, r_t0, r_zero, 16'd1); // taken
    prog[8]  = itype_word(`OP_ORI, r_zero, r_v0, 16'h0BAD);
    prog[9]  = itype_word(`OP_BEQ, r_t0, r_zero, 16'd1); // not taken
    prog[10] = jump_word(vec + 32'd52);
    prog[11] = itype_word(`OP_ORI, r_zero, r_v0, 16'h0BAD);
    prog[13] = itype_word(`OP_BEQ, r_zero, r_zero, 16'd3);
    prog[14] = itype_word(`OP_ORI, r_zero, r_v0, 16'h0022);
    prog[15] = jump_word(vec + 32'd60); // parks here
    prog[17] = itype_word(`OP_BEQ, r_zero, r_zero, 16'hFFFC); // backward to word 14
    apply_reset();
    run_cycles(2);
    pc = branch_dest(vec + 32'd8, 16'd2);
    run_cycles(1);
    check_value("beq_taken_pc", pc, instr_address);
    check_value("beq_skip_v0", 32'h0, register_v0);
    pc = pc + 32'd4;
    run_cycles(1);
    check_value("bne_untaken_pc", pc, instr_address);
    run_cycles(1);
    check_value("bne_untaken_v0", 32'h0011, register_v0);
    pc = branch_dest(pc + 32'd4, 16'd1);
    run_cycles(1);
    check_value("bne_taken_pc", pc, instr_address);
    check_value("bne_skip_v0", 32'h0011, register_v0);
    pc = pc + 32'd4;
    run_cycles(1);
    check_value("beq_untaken_pc", pc, instr_address);
    pc = vec + 32'd52; // where word 10 was assembled to land
    run_cycles(1);
    check_value("j_pc", pc, instr_address);
    check_value("j_skip_v0", 32'h0011, register_v0);
    pc = branch_dest(pc, 16'd3);
    run_cycles(1);
    check_value("beq_forward_pc", pc, instr_address);
    pc = branch_dest(pc, 16'hFFFC);
    run_cycles(1);
    check_value("beq_backward_pc", pc, instr_address);
    wait_for_pc("control_flow", vec + 32'd60, 4);
    check_value("control_flow_v0", 32'h0022, register_v0);
  endtask

  task automatic freeze_and_resume;
    clear_program();
    prog[0] = itype_word(`OP_ORI, r_zero, r_v0, 16'd1);
    prog[1] = itype_word(`OP_ADDIU, r_v0, r_v0, 16'd1);
    prog[2] = itype_word(`OP_ADDIU, r_v0, r_v0, 16'd1);
    prog[3] = itype_word(`OP_ADDIU, r_v0, r_v0, 16'd1);
    prog[4] = jump_word(vec + 32'd16);
    apply_reset();
    run_cycles(2);
    @(posedge clk);
    clk_enable <= 1'b0; // this edge still runs word 2
    @(negedge clk);
    for (int i = 0; i < 6; i++) begin
      check_value($sformatf("frozen_pc_%0d", i), vec + 32'd12, instr_address);
      check_value($sformatf("frozen_v0_%0d", i), 32'd3, register_v0);
      run_cycles(1);
    end
    @(posedge clk);
    clk_enable <= 1'b1;
    wait_for_pc("freeze_and_resume", vec + 32'd16, 4);
    check_value("resumed_v0", 32'd4, register_v0);
  endtask

  initial begin
    reset = 1'b1;
    clk_enable = 1'b0;
    lfsr = 32'hac4367b7;
    checks = 0;
    errors = 0;
    timeouts = 0;
    clear_program();
    reset_and_idle();
    immediate_ops();
    rtype_ops();
    zero_register();
    control_flow();
    freeze_and_resume();
    $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: mips_core.f
+incdir+design
design/mips_pkg.sv
design/reg_file.sv
design/program_counter.sv
design/alu.sv
design/control_decoder.sv
design/mips_core.sv
test/mips_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing -f mips_core.f --top-module mips_core_tb -Mdir obj_dir &&
./obj_dir/Vmips_core_tb | tee /dev/stderr | grep -q "Simulation finished: PASS" &&
echo "run_sim: passed" ||
{ echo "run_sim: failed"; exit 1; }
